/* logic/agcLevelDetect.sv */
`timescale 1ns/1ps
`default_nettype none

module agcLevelDetect (
    input  wire logic                               clk,
    input  wire logic                               rstN,
    input  wire logic                               clkEn,
    input  wire logic signed [agcPkg::sampleWidth-1:0] rx,
    output logic [agcPkg::logWidth-1:0]            logVal,
    output logic                                    levelValid
);
    import agcPkg::*;

    logic [sampleWidth-1:0] absFull;    // 0 .. 2^17
    logic [levelWidth-1:0]  absClip;
    logic [levelWidth-1:0]  rxLevel;
    logic                   levelLoaded;    // clkEn one clk late
    logic [15:0]            lin;
    logic [3:0]             lead;
    logic [15:0]            norm;
    logic [logWidth-1:0]    logNext;

    // ########################################################################
    // Magnitude
    // ########################################################################
    // Most negative code negates to 2^17, caught by the clip below
    assign absFull = rx[sampleWidth-1] ? sampleWidth'(-rx) : rx;
    assign absClip = absFull[sampleWidth-1] ? '1 : absFull[levelWidth-1:0];

    always_ff @(posedge clk) begin
        if (clkEn) begin
            rxLevel <= absClip;
        end
    end

    // ########################################################################
    // Log2, leading one plus four bits below it
    // ########################################################################
    assign lin = rxLevel[levelWidth-1 -: 16];    // Drop the LSB

    always_comb begin
        lead = '0;
        for (int i = 0; i < 16; i++) begin
            if (lin[i]) lead = 4'(i);    // Highest set bit wins
        end
        norm    = lin << (4'd15 - lead);    // Leading one to bit 15
        logNext = (lin == '0) ? '0 : {lead, norm[14:11]};
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            levelLoaded <= 1'b0;
            levelValid  <= 1'b0;
        end else begin
            levelLoaded <= clkEn;
            levelValid  <= levelLoaded;
        end
    end

    always_ff @(posedge clk) begin
        if (levelLoaded) begin
            logVal <= logNext;
        end
    end

endmodule

`default_nettype wire

/* logic/agcLoopFilter.sv */
`timescale 1ns/1ps
`default_nettype none

module agcLoopFilter (
    input  wire logic                                  clk,
    input  wire logic                                  rstN,
    input  wire agcPkg::agcCfg_t                       cfg,
    input  wire agcPkg::agcMode_t                      mode,
    input  wire logic [agcPkg::logWidth-1:0]           logVal,
    input  wire logic                                  levelValid,
    input  wire logic                                  windowEnd,
    output logic signed [agcPkg::errSumWidth-1:0]      errSum,
    output logic [agcPkg::gainWidth-1:0]               gain
);
    import agcPkg::*;

    logic signed [logWidth:0]      err;       // ref - log, 9 bits
    logic signed [errSumWidth-1:0] errCur;
    logic signed [errSumWidth-1:0] acc;
    logic [3:0]                    shiftSel;
    logic signed [integWidth+1:0]  step;
    logic signed [integWidth+1:0]  sum;       // Two guard bits
    logic [integWidth-1:0]         integ;
    logic [integWidth-1:0]         integNext;

    // ########################################################################
    // Window accumulator
    // ########################################################################
    assign err    = $signed({1'b0, cfg.refLevel}) - $signed({1'b0, logVal});
    assign errCur = levelValid ? errSumWidth'(err) : '0;
    assign errSum = acc + errCur;    // Includes the sample closing the window

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            acc <= '0;
        end else if (!cfg.loopEnable || windowEnd) begin
            acc <= '0;
        end else begin
            acc <= errSum;
        end
    end

    // ########################################################################
    // Integrator, clamped at 0 and all-ones
    // ########################################################################
    assign shiftSel = (mode == modeTrack) ? cfg.trkShift : cfg.acqShift;

    always_comb begin
        step = errSum;    // Sign extend
        step = step <<< shiftSel;
        sum  = $signed({2'b00, integ}) + step;
        if (sum < 0) begin
            integNext = '0;
        end else if (sum > $signed({2'b00, {integWidth{1'b1}}})) begin
            integNext = '1;
        end else begin
            integNext = sum[integWidth-1:0];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            integ <= '0;
        end else if (windowEnd && mode != modeIdle) begin
            integ <= integNext;    // Idle freezes the gain
        end
    end

    assign gain = integ[integWidth-1 -: gainWidth];

endmodule

`default_nettype wire

/* logic/agcModeCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module agcModeCtrl (
    input  wire logic                                 clk,
    input  wire logic                                 rstN,
    input  wire agcPkg::agcCfg_t                      cfg,
    input  wire logic                                 windowEnd,
    input  wire logic signed [agcPkg::errSumWidth-1:0] errSum,
    output agcPkg::agcMode_t                          mode
);
    import agcPkg::*;

    logic [errSumWidth-1:0] errMag;    // Unsigned, -2^16 fits
    logic [7:0]             lockCnt;
    logic [8:0]             lockNext;
    logic                   smallErr;
    logic                   largeErr;

    assign errMag   = errSum[errSumWidth-1] ? errSumWidth'(-errSum) : errSum;
    assign smallErr = errMag <= errSumWidth'(cfg.lockThreshold);
    assign largeErr = {1'b0, errMag} > {cfg.lockThreshold, 2'b00};    // 4x threshold
    assign lockNext = {1'b0, lockCnt} + 9'd1;

    // ########################################################################
    // Acquire / track FSM
    // ########################################################################
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mode    <= modeIdle;
            lockCnt <= '0;
        end else if (!cfg.loopEnable) begin
            mode    <= modeIdle;
            lockCnt <= '0;
        end else begin
            case (mode)
                modeIdle: begin
                    mode    <= modeAcquire;
                    lockCnt <= '0;
                end
                modeAcquire: if (windowEnd) begin
                    if (!smallErr) begin
                        lockCnt <= '0;                  // Streak broken
                    end else if (lockNext >= {1'b0, cfg.lockCount}) begin
                        mode    <= modeTrack;
                        lockCnt <= '0;
                    end else begin
                        lockCnt <= lockNext[7:0];
                    end
                end
                modeTrack: if (cfg.forceAcquire || (windowEnd && largeErr)) begin
                    mode    <= modeAcquire;
                    lockCnt <= '0;
                end
                default: mode <= modeIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/agcPkg.sv */
`default_nettype none

package agcPkg;

    // ########################################################################
    // Datapath widths
    // ########################################################################
    localparam int sampleWidth = 18;    // rx from the bit synchronizer
    localparam int levelWidth  = 17;    // Clipped magnitude
    localparam int logWidth    = 8;     // 4.4 log2 of top 16 level bits
    localparam int errSumWidth = 17;    // Signed window total
    localparam int gainWidth   = 18;    // Amplifier control word
    localparam int integWidth  = 32;    // Loop integrator

    // Register word addresses
    localparam logic [2:0] addrCtrl     = 3'd0;
    localparam logic [2:0] addrRefLevel = 3'd1;
    localparam logic [2:0] addrGains    = 3'd2;
    localparam logic [2:0] addrDwell    = 3'd3;
    localparam logic [2:0] addrLock     = 3'd4;
    localparam logic [2:0] addrStatus   = 3'd5;    // Read only

    typedef enum logic [1:0] {
        modeIdle    = 2'd0,
        modeAcquire = 2'd1,
        modeTrack   = 2'd2
    } agcMode_t;

    typedef struct packed {
        logic        loopEnable;
        logic        forceAcquire;    // One clk wide
        logic [7:0]  refLevel;        // Same 4.4 format as the log
        logic [3:0]  acqShift;
        logic [3:0]  trkShift;
        logic [7:0]  dwell;           // Samples per window, 0 acts as 1
        logic [15:0] lockThreshold;
        logic [7:0]  lockCount;
    } agcCfg_t;

    typedef struct packed {
        agcMode_t               mode;
        logic [gainWidth-1:0]   gain;
    } agcStatus_t;

    // Wishbone classic, word addressed
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wbReq_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbRsp_t;

endpackage

`default_nettype wire

/* logic/agcUpdateTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module agcUpdateTimer (
    input  wire logic       clk,
    input  wire logic       rstN,
    input  wire logic       enable,
    input  wire logic       levelValid,
    input  wire logic [7:0] dwell,
    output logic            windowEnd
);

    logic [7:0] remain;       // 0 means reload on next sample
    logic [7:0] dwellEff;
    logic [7:0] current;      // Count seen by this sample

    assign dwellEff  = (dwell == 8'd0) ? 8'd1 : dwell;
    assign current   = (remain == 8'd0) ? dwellEff : remain;

    // Last sample of the window, same cycle as its levelValid
    assign windowEnd = enable & levelValid & (current == 8'd1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            remain <= '0;
        end else if (!enable) begin
            remain <= '0;    // Fresh window on enable
        end else if (levelValid) begin
            remain <= windowEnd ? 8'd0 : current - 8'd1;
        end
    end

endmodule

`default_nettype wire

/* logic/agcWbRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module agcWbRegs (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire agcPkg::wbReq_t     wbReq,
    output agcPkg::wbRsp_t          wbRsp,
    input  wire agcPkg::agcStatus_t status,
    output agcPkg::agcCfg_t         cfg
);
    import agcPkg::*;

    agcCfg_t     cfgQ;
    logic        ackQ;
    logic [31:0] datQ;     // Read data, held with ack
    logic [31:0] rdData;
    logic        access;   // New classic cycle this clk
    logic        wrEn;

    assign access = wbReq.cyc & wbReq.stb & ~ackQ;
    assign wrEn   = access & wbReq.we;

    // ########################################################################
    // Read mux
    // ########################################################################
    always_comb begin
        rdData = '0;    // Unmapped reads give zero
        case (wbReq.adr)
            addrCtrl:     rdData[0]     = cfgQ.loopEnable;    // Bit1 self-clears
            addrRefLevel: rdData[7:0]   = cfgQ.refLevel;
            addrGains:    rdData[7:0]   = {cfgQ.trkShift, cfgQ.acqShift};
            addrDwell:    rdData[7:0]   = cfgQ.dwell;
            addrLock:     rdData[23:0]  = {cfgQ.lockCount, cfgQ.lockThreshold};
            addrStatus:   rdData        = {status.gain, 12'd0, status.mode};
            default:      rdData        = '0;
        endcase
    end

    // Single-cycle ack, dropped before the master can re-trigger
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ackQ <= 1'b0;
        end else begin
            ackQ <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            datQ <= rdData;
        end
    end

    // ########################################################################
    // Control registers, byte lanes per sel
    // ########################################################################
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfgQ <= '0;
        end else begin
            cfgQ.forceAcquire <= 1'b0;    // Pulse by default
            if (wrEn) begin
                case (wbReq.adr)
                    addrCtrl: if (wbReq.sel[0]) begin
                        cfgQ.loopEnable   <= wbReq.dat[0];
                        cfgQ.forceAcquire <= wbReq.dat[1];
                    end
                    addrRefLevel: if (wbReq.sel[0]) cfgQ.refLevel <= wbReq.dat[7:0];
                    addrGains: if (wbReq.sel[0]) begin
                        cfgQ.acqShift <= wbReq.dat[3:0];
                        cfgQ.trkShift <= wbReq.dat[7:4];
                    end
                    addrDwell: if (wbReq.sel[0]) cfgQ.dwell <= wbReq.dat[7:0];
                    addrLock: begin
                        if (wbReq.sel[0]) cfgQ.lockThreshold[7:0]  <= wbReq.dat[7:0];
                        if (wbReq.sel[1]) cfgQ.lockThreshold[15:8] <= wbReq.dat[15:8];
                        if (wbReq.sel[2]) cfgQ.lockCount           <= wbReq.dat[23:16];
                    end
                    default: ;    // Status and holes ignore writes
                endcase
            end
        end
    end

    assign cfg       = cfgQ;
    assign wbRsp.ack = ackQ;
    assign wbRsp.dat = datQ;

endmodule

`default_nettype wire

/* logic/pcmAgcLoop.sv */
`timescale 1ns/1ps
`default_nettype none

module pcmAgcLoop (
    input  wire logic                                  clk,
    input  wire logic                                  rstN,
    input  wire logic                                  clkEn,
    input  wire logic signed [agcPkg::sampleWidth-1:0] rx,
    input  wire agcPkg::wbReq_t                        wbReq,
    output agcPkg::wbRsp_t                             wbRsp,
    output logic [agcPkg::gainWidth-1:0]               agcGain,
    output agcPkg::agcMode_t                           rxMode
);
    import agcPkg::*;

    agcCfg_t                       cfg;
    agcStatus_t                    status;
    logic [logWidth-1:0]           logVal;
    logic                          levelValid;
    logic                          windowEnd;
    logic signed [errSumWidth-1:0] errSum;

    assign status.mode = rxMode;
    assign status.gain = agcGain;

    // ########################################################################
    // Bus slave and sample path
    // ########################################################################
    agcWbRegs regs_i (
        .clk    (clk),
        .rstN   (rstN),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp),
        .status (status),
        .cfg    (cfg)
    );

    agcLevelDetect detect_i (
        .clk        (clk),
        .rstN       (rstN),
        .clkEn      (clkEn),
        .rx         (rx),
        .logVal     (logVal),
        .levelValid (levelValid)
    );

    agcUpdateTimer timer_i (
        .clk        (clk),
        .rstN       (rstN),
        .enable     (cfg.loopEnable),
        .levelValid (levelValid),
        .dwell      (cfg.dwell),
        .windowEnd  (windowEnd)
    );

    // Mode and filter both act on the same windowEnd edge
    agcModeCtrl modeCtrl_i (
        .clk       (clk),
        .rstN      (rstN),
        .cfg       (cfg),
        .windowEnd (windowEnd),
        .errSum    (errSum),
        .mode      (rxMode)
    );

    agcLoopFilter filter_i (
        .clk        (clk),
        .rstN       (rstN),
        .cfg        (cfg),
        .mode       (rxMode),
        .logVal     (logVal),
        .levelValid (levelValid),
        .windowEnd  (windowEnd),
        .errSum     (errSum),
        .gain       (agcGain)
    );

endmodule

`default_nettype wire

/* pcmAgcLoop.f */
logic/agcPkg.sv
logic/agcWbRegs.sv
logic/agcLevelDetect.sv
logic/agcUpdateTimer.sv
logic/agcModeCtrl.sv
logic/agcLoopFilter.sv
logic/pcmAgcLoop.sv
tb/pcmAgcLoopTb.sv

/* run.sh */
#!/bin/sh
# Build and run the AGC loop testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module pcmAgcLoopTb -f pcmAgcLoop.f \
    -Mdir obj_dir -o pcmAgcLoopSim \
    && ./obj_dir/pcmAgcLoopSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && exit 0 || exit 1

/* tb/pcmAgcLoopTb.sv */
`timescale 1ns/1ps
`default_nettype none

module pcmAgcLoopTb;
    import agcPkg::*;

    // One stimulus row and its expected outcome
    typedef struct packed {
        int       en;           // loopEnable
        int       forceAcq;     // Pulsed with the ctrl write
        int       refLvl;
        int       acqShift;
        int       trkShift;
        int       dwell;
        int       thr;          // lockThreshold
        int       lockCount;
        int       amp;          // rx magnitude with random sign
        int       count;        // Samples in the row, whole windows
        agcMode_t expMode;
        int       expGain;
    } stimRow_t;

    logic                          clk;
    logic                          rstN;
    logic                          clkEn;
    logic signed [sampleWidth-1:0] rx;
    wbReq_t                        wbReq;
    wbRsp_t                        wbRsp;
    logic [gainWidth-1:0]          agcGain;
    agcMode_t                      rxMode;

    stimRow_t    rows [11];
    stimRow_t    cur;                       // Settings of the running row
    integer      seed = 32'h1e56_21f1;
    logic [31:0] word;

    // Reference model state
    longint   predInteg;
    agcMode_t predMode;
    int       predLock;
    int       predAcc;       // Window total so far
    int       predCount;     // Samples in the open window

    pcmAgcLoop dut_i (
        .clk     (clk),
        .rstN    (rstN),
        .clkEn   (clkEn),
        .rx      (rx),
        .wbReq   (wbReq),
        .wbRsp   (wbRsp),
        .agcGain (agcGain),
        .rxMode  (rxMode)
    );

    always #50 clk = ~clk;    // 100 ns period

    // ########################################################################
    // Failure reporting and compares
    // ########################################################################
    task automatic failRun(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkGain(input logic [gainWidth-1:0] got, input logic [gainWidth-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("error agcGain got 0x%05h expected 0x%05h", got, exp));
        end
    endtask

    task automatic checkMode(input agcMode_t got, input agcMode_t exp);
        if (got !== exp) begin
            failRun($sformatf("error rxMode got 0x%0h expected 0x%0h", got, exp));
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("error %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    // ########################################################################
    // Wishbone classic master
    // ########################################################################
    task automatic waitForAck();
        int cycles;
        cycles = 0;
        @(negedge clk);    // Ack sampled mid-cycle
        while (!wbRsp.ack) begin
            if (cycles == 16) begin
                failRun("bus cycle was never acknowledged");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wbWrite(input logic [2:0] wordAdr, input logic [31:0] wrData,
                           input logic [3:0] byteSel);
        @(posedge clk);
        wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: wordAdr, dat: wrData, sel: byteSel};
        waitForAck();
        @(posedge clk);
        wbReq <= '0;    // Drop stb after ack
    endtask

    task automatic wbRead(input logic [2:0] wordAdr, output logic [31:0] rdData);
        @(posedge clk);
        wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: wordAdr, dat: 32'd0, sel: 4'hf};
        waitForAck();
        rdData = wbRsp.dat;    // Valid while ack is high
        @(posedge clk);
        wbReq <= '0;
    endtask

    task automatic writeAndReadBack(input string name, input logic [2:0] wordAdr,
                                    input logic [31:0] wrData, input logic [3:0] byteSel,
                                    input logic [31:0] expData);
        logic [31:0] rdData;
        wbWrite(wordAdr, wrData, byteSel);
        wbRead(wordAdr, rdData);
        checkWord(name, rdData, expData);
    endtask

    // ########################################################################
    // Reference model of the loop
    // ########################################################################
    // 4.4 log2 of the top 16 level bits
    function automatic int logOf(input int mag);
        int top;
        int p;
        top = mag >> 1;
        if (top == 0) begin
            return 0;
        end
        p = 15;
        while (((top >> p) & 1) == 0) begin
            p--;
        end
        return p * 16 + (((top << 4) >> p) & 15);    // Four bits under the leading one
    endfunction

    task automatic closeWindow();
        int     errMag;
        int     shift;
        longint integMax;
        integMax = (longint'(1) << integWidth) - 1;
        shift    = (predMode == modeTrack) ? cur.trkShift : cur.acqShift;
        errMag   = (predAcc < 0) ? -predAcc : predAcc;
        if (predMode != modeIdle) begin
            predInteg = predInteg + longint'(predAcc) * (longint'(1) << shift);
            if (predInteg < 0) begin
                predInteg = 0;              // Clamp without wrap
            end else if (predInteg > integMax) begin
                predInteg = integMax;
            end
        end
        // Gain step above used the shift of the old mode
        if (predMode == modeAcquire) begin
            if (errMag > cur.thr) begin
                predLock = 0;
            end else if (predLock + 1 >= cur.lockCount) begin
                predMode = modeTrack;
                predLock = 0;
            end else begin
                predLock++;
            end
        end else if (predMode == modeTrack && errMag > 4 * cur.thr) begin
            predMode = modeAcquire;
            predLock = 0;
        end
        predAcc   = 0;
        predCount = 0;
    endtask

    task automatic predictSample(input logic signed [sampleWidth-1:0] rxVal);
        int mag;
        int dwellEff;
        mag = rxVal;                                  // Sign extended
        if (mag < 0) begin
            mag = -mag;
        end
        if (mag > (1 << levelWidth) - 1) begin
            mag = (1 << levelWidth) - 1;              // Most negative code
        end
        dwellEff = (cur.dwell == 0) ? 1 : cur.dwell;
        if (cur.en != 0) begin
            predAcc = predAcc + cur.refLvl - logOf(mag);
            predCount++;
            if (predCount == dwellEff) begin
                closeWindow();
            end
        end
    endtask

    task automatic configureModel(input stimRow_t row);
        cur = row;
        if (row.en == 0) begin
            predMode  = modeIdle;    // Gain frozen
            predLock  = 0;
            predAcc   = 0;
            predCount = 0;
        end else begin
            if (predMode == modeIdle) begin
                predMode = modeAcquire;
                predLock = 0;
            end
            if (row.forceAcq != 0 && predMode == modeTrack) begin
                predMode = modeAcquire;
                predLock = 0;
            end
        end
    endtask

    // ########################################################################
    // Stimulus
    // ########################################################################
    task automatic sendSamples(input stimRow_t row);
        int                            i;
        integer                        draw;
        logic signed [sampleWidth-1:0] rxVal;
        for (i = 0; i < row.count; i++) begin
            draw  = $random(seed);
            rxVal = draw[0] ? sampleWidth'(-row.amp) : sampleWidth'(row.amp);    // Random sign
            @(posedge clk);
            clkEn <= 1'b1;
            rx    <= rxVal;
            predictSample(rxVal);
            @(posedge clk);
            clkEn <= 1'b0;
            repeat (2) @(posedge clk);    // clkEn every fourth cycle
        end
    endtask

    task automatic runRow(input stimRow_t row);
        logic [gainWidth-1:0] expGain;
        logic [31:0]          statusWord;
        wbWrite(addrRefLevel, 32'(row.refLvl), 4'h1);
        wbWrite(addrGains, 32'(row.trkShift * 16 + row.acqShift), 4'h1);
        wbWrite(addrDwell, 32'(row.dwell), 4'h1);
        wbWrite(addrLock, 32'(row.lockCount * 65536 + row.thr), 4'h7);
        wbWrite(addrCtrl, 32'(row.forceAcq * 2 + row.en), 4'h1);    // Ctrl last
        configureModel(row);
        sendSamples(row);
        repeat (6) @(posedge clk);    // Last window reaches the integrator
        @(negedge clk);
        expGain = gainWidth'(predInteg >> (integWidth - gainWidth));
        if (int'(expGain) != row.expGain || predMode != row.expMode) begin
            failRun("reference model and stimulus table disagree");
        end
        checkGain(agcGain, expGain);
        checkMode(rxMode, predMode);
        wbRead(addrStatus, statusWord);
        checkWord("status", statusWord, (32'(expGain) << 14) | 32'(predMode));
    endtask

    // en force ref acq trk dwell thr lockCnt amp count mode gain
    task automatic fillTable();
        rows[0]  = '{1, 0, 'h80, 10, 6, 4, 10, 3, 32, 16, modeAcquire, 64};      // Gain rises
        rows[1]  = '{1, 0, 'h80, 10, 6, 4, 10, 3, 3000, 8, modeAcquire, 44};     // Falls, log 0xa7
        rows[2]  = '{1, 0, 'hff, 15, 6, 255, 10, 3, 2, 1020, modeAcquire, 'h3ffff};
        rows[3]  = '{1, 0, 'h00, 15, 6, 255, 10, 3, 131072, 1020, modeAcquire, 0};
        rows[4]  = '{1, 0, 'h80, 10, 6, 4, 10, 3, 32, 16, modeAcquire, 64};
        rows[5]  = '{1, 0, 'h80, 10, 6, 4, 10, 3, 512, 12, modeTrack, 64};       // Lock
        rows[6]  = '{1, 0, 'h80, 10, 6, 4, 20, 3, 256, 32, modeTrack, 66};       // Track steps
        rows[7]  = '{1, 1, 'h80, 10, 6, 4, 20, 3, 512, 4, modeAcquire, 66};      // Forced
        rows[8]  = '{1, 0, 'h80, 10, 6, 4, 20, 3, 512, 8, modeTrack, 66};
        rows[9]  = '{1, 0, 'h80, 10, 6, 4, 20, 3, 32, 4, modeAcquire, 67};       // Large error
        rows[10] = '{0, 0, 'h80, 10, 6, 4, 20, 3, 32, 8, modeIdle, 67};          // Frozen
    endtask

    initial begin
        clk       = 1'b0;
        rstN      = 1'b0;
        clkEn     = 1'b0;
        rx        = '0;
        wbReq     = '0;
        cur       = '0;
        predInteg = 0;
        predMode  = modeIdle;
        predLock  = 0;
        predAcc   = 0;
        predCount = 0;
        fillTable();
        repeat (2) @(posedge clk);    // Reset over 2 edges
        rstN <= 1'b1;
        @(negedge clk);

        // Reset state and register access
        checkGain(agcGain, '0);
        checkMode(rxMode, modeIdle);
        wbRead(addrStatus, word);
        checkWord("status", word, 32'd0);
        wbRead(3'd6, word);
        checkWord("unmapped word 6", word, 32'd0);
        wbRead(3'd7, word);
        checkWord("unmapped word 7", word, 32'd0);
        writeAndReadBack("ctrl", addrCtrl, 32'h3, 4'h1, 32'h1);    // forceAcquire reads 0
        writeAndReadBack("ctrl", addrCtrl, 32'h0, 4'h1, 32'h0);
        writeAndReadBack("refLevel", addrRefLevel, 32'ha5, 4'h1, 32'ha5);
        writeAndReadBack("gains", addrGains, 32'h5c, 4'h1, 32'h5c);
        writeAndReadBack("dwell", addrDwell, 32'h37, 4'h1, 32'h37);
        writeAndReadBack("lock", addrLock, 32'h002b_1234, 4'h7, 32'h002b_1234);
        writeAndReadBack("lock", addrLock, 32'hffff_ffff, 4'h2, 32'h002b_ff34);    // Lane 1 only

        foreach (rows[i]) begin
            runRow(rows[i]);
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
